//--- logic/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
  input  mipsPkg::aluOpT aluOp,
  input  logic [31:0]    a,
  input  logic [31:0]    b,
  output logic [31:0]    result,
  output logic           equal
);
  import mipsPkg::*;

  logic lessThan;

  assign lessThan = ($signed(a) < $signed(b));

  always_comb begin
    case (aluOp)
      aluAdd:  result = a + b;
      aluSub:  result = a - b;
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      aluXor:  result = a ^ b;
      aluSlt:  result = {31'b0, lessThan};
      aluPass: result = b;
      default: result = a + b;
    endcase
  end

  assign equal = (a == b);  // for beq and bne

endmodule

//--- logic/execStage.sv
`timescale 1ns/1ps

module execStage (
  input  logic            clk,
  input  logic            arstN,
  input  logic [31:0]     inst,
  input  logic [31:0]     instPc,
  input  logic            instValid,
  input  logic            dataGrant,
  input  logic [31:0]     dataRdata,
  input  logic            dataRvalid,
  output mipsPkg::memReqT dataReq,
  output logic            redirect,
  output logic [31:0]     redirectPc,
  output mipsPkg::retireT retire
);
  import mipsPkg::*;

  typedef enum logic {stExec, stLoadWait} stateT;

  stateT       stateQ;
  stateT       stateD;
  ctrlT        ctrl;
  logic        active;
  logic [31:0] rsData;
  logic [31:0] rtData;
  logic [31:0] immExt;
  logic [31:0] aluB;
  logic [31:0] aluResult;
  logic        aluEqual;
  logic [31:0] pcPlus4;
  logic [31:0] brTarget;
  logic [31:0] jTarget;
  logic [4:0]  destReg;
  logic        rfWe;
  logic [4:0]  rfWaddr;
  logic [31:0] rfWdata;
  logic [4:0]  ldRegQ;  // load destination
  logic [31:0] ldPcQ;   // load pc for the trace

  instDecoder uDecoder (.inst(inst), .ctrl(ctrl));

  regFile uRegFile (
    .clk    (clk),
    .arstN  (arstN),
    .raddrA (inst[25:21]),
    .raddrB (inst[20:16]),
    .we     (rfWe),
    .waddr  (rfWaddr),
    .wdata  (rfWdata),
    .rdataA (rsData),
    .rdataB (rtData)
  );

  assign immExt = ctrl.zeroExt ? {16'h0000, inst[15:0]} : {{16{inst[15]}}, inst[15:0]};
  assign aluB   = ctrl.aluSrc ? immExt : rtData;

  aluUnit uAlu (
    .aluOp  (ctrl.aluOp),
    .a      (rsData),
    .b      (aluB),
    .result (aluResult),
    .equal  (aluEqual)
  );

  assign active   = instValid && (stateQ == stExec);
  assign pcPlus4  = instPc + 32'd4;
  assign brTarget = pcPlus4 + {{14{inst[15]}}, inst[15:0], 2'b00};
  assign jTarget  = {pcPlus4[31:28], inst[25:0], 2'b00};  // pseudo-direct
  assign destReg  = ctrl.link ? 5'd31 : (ctrl.regDst ? inst[15:11] : inst[20:16]);

  ////////////////////////////////////////
  // branch resolution
  ////////////////////////////////////////

  always_comb begin
    redirect   = 1'b0;
    redirectPc = brTarget;
    if (active) begin
      case (ctrl.branch)
        brJump: begin
          redirect   = 1'b1;
          redirectPc = jTarget;
        end
        brJumpReg: begin
          redirect   = 1'b1;
          redirectPc = rsData;
        end
        brCond:  redirect = aluEqual ^ ctrl.branchNe;
        default: ;
      endcase
    end
  end

  assign dataReq = '{valid: active && (ctrl.memRead || ctrl.memWrite),
                     write: active && ctrl.memWrite,
                     addr:  aluResult,
                     wdata: rtData};

  ////////////////////////////////////////
  // writeback and load wait
  ////////////////////////////////////////

  always_comb begin
    if (stateQ == stLoadWait) begin
      rfWe    = dataRvalid;
      rfWaddr = ldRegQ;
      rfWdata = dataRdata;
    end else begin
      rfWe    = active && ctrl.regWrite && !ctrl.memToReg;
      rfWaddr = destReg;
      rfWdata = ctrl.link ? pcPlus4 : aluResult;
    end
  end

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      stExec:     if (active && ctrl.memRead && dataGrant) stateD = stLoadWait;
      stLoadWait: if (dataRvalid) stateD = stExec;
      default:    stateD = stExec;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      stateQ <= stExec;
    end else begin
      stateQ <= stateD;
    end
  end

  always_ff @(posedge clk) begin
    if (stateQ == stExec && stateD == stLoadWait) begin
      ldRegQ <= destReg;
      ldPcQ  <= instPc;
    end
  end

  // loads retire from the wait state, everything else on execute
  assign retire = '{valid:  (stateQ == stLoadWait) ? dataRvalid : (active && !ctrl.memRead),
                    pc:     (stateQ == stLoadWait) ? ldPcQ : instPc,
                    regWe:  rfWe,
                    wbReg:  rfWaddr,
                    wbData: rfWdata};

endmodule

//--- logic/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
  input  logic            clk,
  input  logic            arstN,
  input  logic            grant,
  input  logic [31:0]     rdata,
  input  logic            rvalid,
  input  logic            redirect,
  input  logic [31:0]     redirectPc,
  output mipsPkg::memReqT fetchReq,
  output logic [31:0]     inst,
  output logic [31:0]     instPc,
  output logic            instValid
);
  import mipsPkg::*;

  logic [31:0] pcQ;     // next address to fetch
  logic [31:0] reqPcQ;  // address of the fetch in flight
  logic        dropQ;   // fetch in flight is stale

  // always asking, a refused fetch simply repeats
  assign fetchReq = '{valid: 1'b1, write: 1'b0, addr: pcQ, wdata: 32'd0};

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pcQ   <= 32'd0;
      dropQ <= 1'b0;
    end else begin
      if (redirect) begin
        pcQ <= redirectPc;
      end else if (grant) begin
        pcQ <= pcQ + 32'd4;
      end
      dropQ <= redirect && grant;  // response of the flushed slot
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      reqPcQ <= pcQ;
    end
  end

  ////////////////////////////////////////
  // instruction slot
  ////////////////////////////////////////

  assign instValid = rvalid && !dropQ;
  assign inst      = instValid ? rdata : nopWord;
  assign instPc    = reqPcQ;

endmodule

//--- logic/instDecoder.sv
`timescale 1ns/1ps

module instDecoder (
  input  logic [31:0]   inst,
  output mipsPkg::ctrlT ctrl
);
  import mipsPkg::*;

  opcodeT opcode;
  functT  funct;

  assign opcode = opcodeT'(inst[31:26]);
  assign funct  = functT'(inst[5:0]);

  always_comb begin
    ctrl = '0;  // inactive unless decoded below
    case (opcode)
      opSpecial: begin
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
        case (funct)
          fnAdd: ctrl.aluOp = aluAdd;
          fnSub: ctrl.aluOp = aluSub;
          fnAnd: ctrl.aluOp = aluAnd;
          fnOr:  ctrl.aluOp = aluOr;
          fnXor: ctrl.aluOp = aluXor;
          fnSlt: ctrl.aluOp = aluSlt;
          fnJr: begin
            ctrl.regDst   = 1'b0;
            ctrl.regWrite = 1'b0;  // jr writes nothing
            ctrl.aluOp    = aluPass;
            ctrl.branch   = brJumpReg;
          end
          default: begin
            ctrl.regDst   = 1'b0;  // unknown funct acts as nop
            ctrl.regWrite = 1'b0;
          end
        endcase
      end
      opAddi: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;
        ctrl.regWrite = 1'b1;
      end
      opAndi, opOri, opXori: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.zeroExt  = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = (opcode == opAndi) ? aluAnd :
                        (opcode == opOri)  ? aluOr  : aluXor;
      end
      opSlti: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluSlt;
        ctrl.regWrite = 1'b1;
      end
      opLw: begin
        ctrl.aluSrc   = 1'b1;  // base plus offset
        ctrl.aluOp    = aluAdd;
        ctrl.memRead  = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      opSw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;
        ctrl.memWrite = 1'b1;
      end
      opBeq, opBne: begin
        ctrl.aluOp    = aluSub;
        ctrl.branch   = brCond;
        ctrl.branchNe = (opcode == opBne);
      end
      opJ: begin
        ctrl.aluOp  = aluPass;
        ctrl.branch = brJump;
      end
      opJal: begin
        ctrl.aluOp    = aluPass;
        ctrl.branch   = brJump;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;  // pc+4 into r31
      end
      default: ;  // unknown opcode stays a nop
    endcase

    // an all-zero word is a nop whatever the fields say
    if (inst == nopWord) begin
      ctrl = '0;
    end
  end

endmodule

//--- logic/memArbiter.sv
`timescale 1ns/1ps

module memArbiter (
  input  logic            clk,
  input  logic            arstN,
  input  mipsPkg::memReqT fetchReq,
  input  mipsPkg::memReqT dataReq,
  input  logic [31:0]     memRdata,
  output mipsPkg::memReqT memReq,
  output logic            fetchGrant,
  output logic            dataGrant,
  output logic [31:0]     fetchRdata,
  output logic            fetchRvalid,
  output logic [31:0]     dataRdata,
  output logic            dataRvalid
);

  logic respQ;       // read data due this cycle
  logic ownerDataQ;  // that read belongs to execute

  // data side always wins
  assign dataGrant  = dataReq.valid;
  assign fetchGrant = fetchReq.valid && !dataReq.valid;
  assign memReq     = dataGrant ? dataReq : fetchReq;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      respQ      <= 1'b0;
      ownerDataQ <= 1'b0;
    end else begin
      respQ      <= (dataGrant && !dataReq.write) || (fetchGrant && !fetchReq.write);
      ownerDataQ <= dataGrant && !dataReq.write;  // writes get no response
    end
  end

  assign fetchRdata  = memRdata;
  assign dataRdata   = memRdata;
  assign fetchRvalid = respQ && !ownerDataQ;
  assign dataRvalid  = respQ && ownerDataQ;

endmodule

//--- logic/mipsCore.sv
`timescale 1ns/1ps

module mipsCore (
  input  logic            clk,
  input  logic            arstN,
  output mipsPkg::memReqT memReq,
  input  logic [31:0]     memRdata,
  output mipsPkg::retireT retire
);
  import mipsPkg::*;

  memReqT      fetchReq;
  memReqT      dataReq;
  logic        fetchGrant;
  logic        dataGrant;
  logic [31:0] fetchRdata;
  logic        fetchRvalid;
  logic [31:0] dataRdata;
  logic        dataRvalid;
  logic [31:0] inst;
  logic [31:0] instPc;
  logic        instValid;
  logic        redirect;
  logic [31:0] redirectPc;

  fetchUnit uFetch (
    .clk        (clk),
    .arstN      (arstN),
    .grant      (fetchGrant),
    .rdata      (fetchRdata),
    .rvalid     (fetchRvalid),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .fetchReq   (fetchReq),
    .inst       (inst),
    .instPc     (instPc),
    .instValid  (instValid)
  );

  execStage uExec (
    .clk        (clk),
    .arstN      (arstN),
    .inst       (inst),
    .instPc     (instPc),
    .instValid  (instValid),
    .dataGrant  (dataGrant),
    .dataRdata  (dataRdata),
    .dataRvalid (dataRvalid),
    .dataReq    (dataReq),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .retire     (retire)
  );

  memArbiter uArbiter (
    .clk         (clk),
    .arstN       (arstN),
    .fetchReq    (fetchReq),
    .dataReq     (dataReq),
    .memRdata    (memRdata),
    .memReq      (memReq),
    .fetchGrant  (fetchGrant),
    .dataGrant   (dataGrant),
    .fetchRdata  (fetchRdata),
    .fetchRvalid (fetchRvalid),
    .dataRdata   (dataRdata),
    .dataRvalid  (dataRvalid)
  );

endmodule

//--- logic/mipsPkg.sv
package mipsPkg;

  ////////////////////////////////////////
  // instruction fields
  ////////////////////////////////////////

  typedef enum logic [5:0] {
    opSpecial = 6'h00,  // r-type, see functT
    opJ       = 6'h02,
    opJal     = 6'h03,
    opBeq     = 6'h04,
    opBne     = 6'h05,
    opAddi    = 6'h08,
    opSlti    = 6'h0a,
    opAndi    = 6'h0c,
    opOri     = 6'h0d,
    opXori    = 6'h0e,
    opLw      = 6'h23,
    opSw      = 6'h2b
  } opcodeT;

  typedef enum logic [5:0] {
    fnJr  = 6'h08,
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnOr  = 6'h25,
    fnXor = 6'h26,
    fnSlt = 6'h2a
  } functT;

  typedef enum logic [3:0] {
    aluAdd  = 4'd0,
    aluSub  = 4'd1,
    aluAnd  = 4'd2,
    aluOr   = 4'd3,
    aluXor  = 4'd4,
    aluSlt  = 4'd5,  // signed compare
    aluPass = 4'd6   // forwards b
  } aluOpT;

  typedef enum logic [1:0] {
    brNone    = 2'd0,
    brJump    = 2'd1,
    brJumpReg = 2'd2,
    brCond    = 2'd3
  } branchT;

  ////////////////////////////////////////
  // bundles
  ////////////////////////////////////////

  typedef struct packed {
    logic   regDst;    // rd instead of rt
    logic   aluSrc;    // immediate as b operand
    aluOpT  aluOp;
    logic   memRead;
    logic   memWrite;
    logic   memToReg;
    logic   regWrite;
    branchT branch;
    logic   branchNe;  // bne
    logic   link;      // jal writes r31
    logic   zeroExt;   // logical immediates
  } ctrlT;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;   // byte address, word aligned
    logic [31:0] wdata;
  } memReqT;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic        regWe;
    logic [4:0]  wbReg;
    logic [31:0] wbData;
  } retireT;

  localparam logic [31:0] nopWord = 32'h0000_0000;

endpackage

//--- logic/regFile.sv
`timescale 1ns/1ps

module regFile (
  input  logic        clk,
  input  logic        arstN,
  input  logic [4:0]  raddrA,
  input  logic [4:0]  raddrB,
  input  logic        we,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata,
  output logic [31:0] rdataA,
  output logic [31:0] rdataB
);

  logic [31:0] regs [32];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;  // r0 never written
    end
  end

  assign rdataA = (raddrA == 5'd0) ? 32'd0 : regs[raddrA];
  assign rdataB = (raddrB == 5'd0) ? 32'd0 : regs[raddrB];

endmodule

//--- tb/mipsCoreTb.sv
`timescale 1ns/1ps

module mipsCoreTb;
  import mipsPkg::*;

  // program lengths, used for the run limit
  localparam int arithLen   = 14;
  localparam int storeLen   = 5;
  localparam int branchLen  = 10;
  localparam int jumpLen    = 7;
  localparam int mixedLen   = 8;
  localparam int nopLen     = 4;
  localparam int cycleLimit =
    3 * (arithLen + storeLen + branchLen + jumpLen + mixedLen + nopLen) + 200;

  logic        clk;
  logic        arstN;
  memReqT      memReq;
  logic [31:0] memRdata;
  retireT      retire;

  logic [31:0] mem [1024];  // word addressed
  logic [31:0] rdNext;      // read data for the next cycle
  retireT      retQ [$];
  memReqT      wrQ [$];
  int          cycles;

  mipsCore dut (
    .clk      (clk),
    .arstN    (arstN),
    .memReq   (memReq),
    .memRdata (memRdata),
    .retire   (retire)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  ////////////////////////////////////////
  // memory model and trace capture
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (memReq.valid && memReq.write) begin
      mem[memReq.addr[11:2]] = memReq.wdata;  // write lands at this edge
      if (arstN) wrQ.push_back(memReq);
    end else if (memReq.valid) begin
      rdNext = mem[memReq.addr[11:2]];
    end
    if (arstN && retire.valid) retQ.push_back(retire);
  end

  always @(negedge clk) begin
    memRdata = rdNext;  // valid through the cycle after the request
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycleLimit) begin
      $display("Timeout: the core stopped retiring after %0d cycles", cycles);
      $display("tests failed");
      $fatal(1);
    end
  end

  ////////////////////////////////////////
  // encoders and rules
  ////////////////////////////////////////

  function automatic logic [31:0] encR(input functT fn, input logic [4:0] rd,
                                       input logic [4:0] rs, input logic [4:0] rt);
    return {opSpecial, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] encI(input opcodeT op, input logic [4:0] rt,
                                       input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encJ(input opcodeT op, input logic [31:0] target);
    return {op, target[27:2]};
  endfunction

  function automatic logic [31:0] sext(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  // offset counts words from the slot after the branch
  function automatic logic [31:0] branchTo(input logic [31:0] pc, input logic [15:0] off);
    return pc + 32'd4 + (sext(off) << 2);
  endfunction

  ////////////////////////////////////////
  // checking
  ////////////////////////////////////////

  task automatic checkVal(input string test, input string what,
                          input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s %s: expected %h, actual %h", test, what, expected, actual);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic expectRetire(input string test, input logic [31:0] pc, input logic we,
                              input logic [4:0] rd, input logic [31:0] data);
    retireT r;
    r = retQ.pop_front();
    checkVal(test, "pc", pc, r.pc);
    checkVal(test, "regWe", we, r.regWe);
    if (we) begin
      checkVal(test, "wbReg", rd, r.wbReg);
      checkVal(test, "wbData", data, r.wbData);
    end
  endtask

  task automatic expectQuiet(input string test, input logic [31:0] pc);
    expectRetire(test, pc, 1'b0, 5'd0, 32'd0);
  endtask

  task automatic expectStore(input string test, input logic [31:0] addr,
                             input logic [31:0] data);
    memReqT w;
    w = wrQ.pop_front();
    checkVal(test, "store addr", addr, w.addr);
    checkVal(test, "store data", data, w.wdata);
  endtask

  task automatic waitRetires(input int n);
    while (retQ.size() < n) @(negedge clk);
  endtask

  // holds the core in reset and fills the memory with unknown-opcode nops
  // that carry their own word index
  task automatic beginReset();
    @(negedge clk);
    arstN = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = {6'h3f, 26'(i)};
    end
  endtask

  task automatic releaseReset();
    repeat (2) @(negedge clk);
    retQ.delete();
    wrQ.delete();
    arstN = 1'b1;
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic arithTest();
    logic [15:0] immA;
    logic [15:0] immB;
    logic [15:0] immC;
    logic [31:0] r1;
    logic [31:0] r2;
    immA = 16'($urandom);
    immB = 16'($urandom);
    immC = 16'($urandom);
    r1   = sext(immA);
    r2   = sext(immB);
    beginReset();
    mem[0]  = encI(opAddi, 1, 0, immA);
    mem[1]  = encI(opAddi, 2, 0, immB);
    mem[2]  = encR(fnAdd, 3, 1, 2);
    mem[3]  = encR(fnSub, 4, 1, 2);
    mem[4]  = encR(fnAnd, 5, 1, 2);
    mem[5]  = encR(fnOr, 6, 1, 2);
    mem[6]  = encR(fnXor, 7, 1, 2);
    mem[7]  = encR(fnSlt, 8, 1, 2);
    mem[8]  = encI(opOri, 9, 1, immC);
    mem[9]  = encI(opAndi, 10, 1, immC);
    mem[10] = encI(opXori, 11, 1, immC);
    mem[11] = encI(opSlti, 12, 1, immB);
    mem[12] = encI(opAddi, 0, 1, 16'd5);  // r0 keeps zero
    mem[13] = encR(fnAdd, 13, 0, 0);
    releaseReset();
    waitRetires(arithLen);
    expectRetire("arith", 0, 1'b1, 1, r1);
    expectRetire("arith", 4, 1'b1, 2, r2);
    expectRetire("arith", 8, 1'b1, 3, r1 + r2);
    expectRetire("arith", 12, 1'b1, 4, r1 - r2);
    expectRetire("arith", 16, 1'b1, 5, r1 & r2);
    expectRetire("arith", 20, 1'b1, 6, r1 | r2);
    expectRetire("arith", 24, 1'b1, 7, r1 ^ r2);
    expectRetire("arith", 28, 1'b1, 8, ($signed(r1) < $signed(r2)) ? 32'd1 : 32'd0);
    expectRetire("arith", 32, 1'b1, 9, r1 | {16'h0000, immC});
    expectRetire("arith", 36, 1'b1, 10, r1 & {16'h0000, immC});
    expectRetire("arith", 40, 1'b1, 11, r1 ^ {16'h0000, immC});
    expectRetire("arith", 44, 1'b1, 12, ($signed(r1) < $signed(r2)) ? 32'd1 : 32'd0);
    expectRetire("arith", 48, 1'b1, 0, r1 + 32'd5);
    expectRetire("arith", 52, 1'b1, 13, 32'd0);
  endtask

  task automatic storeLoadTest();
    logic [15:0] immA;
    logic [31:0] d;
    immA = 16'($urandom);
    d    = sext(immA);
    beginReset();
    mem[0] = encI(opAddi, 1, 0, 16'h0100);
    mem[1] = encI(opAddi, 2, 0, immA);
    mem[2] = encI(opSw, 2, 1, 16'd8);
    mem[3] = encI(opLw, 3, 1, 16'd8);
    mem[4] = encR(fnAdd, 4, 3, 3);
    releaseReset();
    waitRetires(storeLen);
    expectRetire("storeLoad", 0, 1'b1, 1, 32'h100);
    expectRetire("storeLoad", 4, 1'b1, 2, d);
    expectQuiet("storeLoad", 8);
    expectRetire("storeLoad", 12, 1'b1, 3, d);
    expectRetire("storeLoad", 16, 1'b1, 4, d + d);
    checkVal("storeLoad", "store count", 1, wrQ.size());
    expectStore("storeLoad", 32'h108, d);
  endtask

  task automatic branchTest();
    beginReset();
    mem[0] = encI(opAddi, 1, 0, 16'd7);
    mem[1] = encI(opAddi, 2, 0, 16'd7);
    mem[2] = encI(opBeq, 2, 1, 16'd1);  // taken
    mem[3] = encI(opAddi, 3, 0, 16'd1);
    mem[4] = encI(opBne, 2, 1, 16'd1);  // not taken
    mem[5] = encI(opAddi, 4, 0, 16'd2);
    mem[6] = encI(opBne, 0, 1, 16'd1);  // taken
    mem[7] = encI(opAddi, 5, 0, 16'd3);
    mem[8] = encI(opBeq, 0, 1, 16'd1);  // not taken
    mem[9] = encI(opAddi, 6, 0, 16'd4);
    releaseReset();
    waitRetires(8);
    expectRetire("branch", 0, 1'b1, 1, 32'd7);
    expectRetire("branch", 4, 1'b1, 2, 32'd7);
    expectQuiet("branch", 8);
    expectQuiet("branch", branchTo(8, 16'd1));
    expectRetire("branch", 20, 1'b1, 4, 32'd2);
    expectQuiet("branch", 24);
    expectQuiet("branch", branchTo(24, 16'd1));
    expectRetire("branch", 36, 1'b1, 6, 32'd4);
  endtask

  task automatic jumpTest();
    logic [31:0] link;
    link = 32'd0 + 32'd4;  // jal sits at pc 0
    beginReset();
    mem[0] = encJ(opJal, 32'd16);
    mem[1] = encI(opAddi, 2, 0, 16'd9);
    mem[2] = encJ(opJ, 32'd24);
    mem[3] = encI(opAddi, 3, 0, 16'd1);
    mem[4] = encI(opAddi, 1, 0, 16'd5);
    mem[5] = encR(fnJr, 0, 31, 0);
    mem[6] = encI(opAddi, 4, 0, 16'd6);
    releaseReset();
    waitRetires(6);
    expectRetire("jump", 0, 1'b1, 31, link);
    expectRetire("jump", 16, 1'b1, 1, 32'd5);
    expectQuiet("jump", 20);
    expectRetire("jump", link, 1'b1, 2, 32'd9);
    expectQuiet("jump", 8);
    expectRetire("jump", 24, 1'b1, 4, 32'd6);
  endtask

  task automatic mixedTest();
    logic [15:0] immA;
    logic [31:0] data0;
    logic [31:0] s1;
    logic [31:0] s2;
    immA  = 16'($urandom);
    data0 = $urandom;
    s1    = data0 + sext(immA);
    s2    = s1 ^ data0;
    beginReset();
    mem[32'h200 >> 2] = data0;
    mem[0] = encI(opAddi, 1, 0, 16'h0200);
    mem[1] = encI(opLw, 2, 1, 16'd0);
    mem[2] = encI(opAddi, 3, 2, immA);  // uses the load right away
    mem[3] = encI(opSw, 3, 1, 16'd4);
    mem[4] = encI(opLw, 4, 1, 16'd4);
    mem[5] = encR(fnXor, 5, 4, 2);
    mem[6] = encI(opSw, 5, 1, 16'd8);
    mem[7] = encI(opLw, 6, 1, 16'd8);
    releaseReset();
    waitRetires(mixedLen + 1);
    expectRetire("mixed", 0, 1'b1, 1, 32'h200);
    expectRetire("mixed", 4, 1'b1, 2, data0);
    expectRetire("mixed", 8, 1'b1, 3, s1);
    expectQuiet("mixed", 12);
    expectRetire("mixed", 16, 1'b1, 4, s1);
    expectRetire("mixed", 20, 1'b1, 5, s2);
    expectQuiet("mixed", 24);
    expectRetire("mixed", 28, 1'b1, 6, s2);
    expectQuiet("mixed", 32);  // trailing nop, no repeat of the last load
    checkVal("mixed", "store count", 2, wrQ.size());
    expectStore("mixed", 32'h204, s1);
    expectStore("mixed", 32'h208, s2);
  endtask

  task automatic nopTest();
    beginReset();
    mem[0] = encI(opAddi, 1, 0, 16'd3);
    mem[1] = nopWord;
    mem[2] = 32'hfc21_1234;  // opcode 0x3f, rt would be r1
    mem[3] = encR(fnAdd, 2, 1, 0);
    releaseReset();
    waitRetires(nopLen);
    expectRetire("nop", 0, 1'b1, 1, 32'd3);
    expectQuiet("nop", 4);
    expectQuiet("nop", 8);
    expectRetire("nop", 12, 1'b1, 2, 32'd3);
  endtask

  initial begin
    arstN    = 1'b0;
    memRdata = 32'd0;
    rdNext   = 32'd0;
    cycles   = 0;
    void'($urandom(95849));
    arithTest();
    storeLoadTest();
    branchTest();
    jumpTest();
    mixedTest();
    nopTest();
    $display("all tests passed");
    $finish;
  end

endmodule

//--- tb/mipsCore_props.sv
`timescale 1ns/1ps

module mipsCoreProps (
  input logic            clk,
  input logic            arstN,
  input mipsPkg::memReqT fetchReq,
  input mipsPkg::memReqT dataReq,
  input logic            fetchGrant,
  input logic            dataGrant,
  input logic            fetchRvalid,
  input logic            dataRvalid
);

  ////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////

  oneGrant: assert property (@(posedge clk) disable iff (!arstN)
    !(fetchGrant && dataGrant))
    else $error("fetch and data granted in the same cycle");

  dataFirst: assert property (@(posedge clk) disable iff (!arstN)
    dataReq.valid |-> !fetchGrant)
    else $error("fetch granted while a data request waits");

  ////////////////////////////////////////
  // responses
  ////////////////////////////////////////

  fetchResp: assert property (@(posedge clk) disable iff (!arstN)
    fetchRvalid |-> $past(fetchGrant && !fetchReq.write))
    else $error("fetch response without a granted fetch read");

  dataResp: assert property (@(posedge clk) disable iff (!arstN)
    dataRvalid |-> $past(dataGrant && !dataReq.write))
    else $error("data response without a granted data read");

endmodule

bind memArbiter mipsCoreProps uProps (
  .clk         (clk),
  .arstN       (arstN),
  .fetchReq    (fetchReq),
  .dataReq     (dataReq),
  .fetchGrant  (fetchGrant),
  .dataGrant   (dataGrant),
  .fetchRvalid (fetchRvalid),
  .dataRvalid  (dataRvalid)
);

//--- verilog.f
logic/mipsPkg.sv
logic/instDecoder.sv
logic/aluUnit.sv
logic/regFile.sv
logic/fetchUnit.sv
logic/execStage.sv
logic/memArbiter.sv
logic/mipsCore.sv
tb/mipsCore_props.sv
tb/mipsCoreTb.sv
